/* files.f */
rtl/uart_rx_pkg.sv
rtl/uart_rx_fsm.sv
rtl/uart_rx_bit_timer.sv
rtl/uart_rx_data_sampler.sv
rtl/uart_rx_deserializer.sv
rtl/uart_rx_frame_checker.sv
rtl/uart_rx_top.sv
tb/uart_rx_assertions.sv
tb/uart_rx_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = uart_rx_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/uart_rx_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_rx_tb;

    localparam int PRESCALE_WIDTH = 6;
    // ten frames and a glitch for each of three prescales.
    localparam int FRAME_COUNT    = 33;
    // worst case of 11 bits at prescale 32 per frame plus margin for gaps.
    localparam int CYCLE_LIMIT    = FRAME_COUNT * 11 * 32 + 2000;

    logic                               CLK;
    logic                               RST;
    logic                               rx_in;
    logic [PRESCALE_WIDTH-1:0]          prescale;
    logic                               par_en;
    logic                               par_odd;
    logic [uart_rx_pkg::DATA_BITS-1:0]  rx_data;
    logic                               rx_valid;
    logic                               rx_err;

    // random source state.
    logic [15:0] lfsr;
    // pending frames with the outcome bit above the byte.
    logic [8:0]  expected[$];
    // line mode of the frames being sent.
    int          cur_p;
    logic        cur_pe;
    logic        cur_po;
    int          errors;
    int          checks;
    int          cycles;

    uart_rx_top #(
        .PRESCALE_WIDTH (PRESCALE_WIDTH)
    ) i_dut (
        .CLK      (CLK),
        .RST      (RST),
        .rx_in    (rx_in),
        .prescale (prescale),
        .par_en   (par_en),
        .par_odd  (par_odd),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_err   (rx_err)
    );

    bind uart_rx_top uart_rx_assertions i_assertions (
        .CLK      (CLK),
        .RST      (RST),
        .rx_valid (rx_valid),
        .rx_err   (rx_err)
    );

    // 4 ns period.
    always #2 CLK = ~CLK;

    // galois form with taps for a 16 bit maximal sequence.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // one lfsr step per bit taken.
    task automatic take_bits(input int n, output logic [15:0] val);
        int i;
        val = '0;
        for (i = 0; i < n; i++)
        begin
            val  = {val[14:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // only changed while the receiver is idle.
    task automatic set_mode(input int p, input logic pe, input logic po);
        cur_p    = p;
        cur_pe   = pe;
        cur_po   = po;
        prescale <= PRESCALE_WIDTH'(p);
        par_en   <= pe;
        par_odd  <= po;
    endtask

    task automatic idle_gap();
        logic [15:0] r;
        take_bits(4, r);
        rx_in <= 1'b1;
        // long enough for the receiver to finish and settle in idle.
        repeat (8 + int'(r[3:0])) @(posedge CLK);
    endtask

    task automatic send_frame(input logic bad_par, input logic bad_stop);
        logic [15:0] r;
        logic [7:0]  data;
        logic        par_bit;
        logic [10:0] bits;
        int          n;
        int          i;
        take_bits(8, r);
        data = r[7:0];
        // even parity keeps the ones count even and odd flips the bit.
        par_bit = (^data) ^ cur_po ^ bad_par;
        // start at index 0 and data lsb first.
        if (cur_pe)
        begin
            bits = {!bad_stop, par_bit, data, 1'b0};
            n    = 11;
        end
        else
        begin
            bits = {1'b1, !bad_stop, data, 1'b0};
            n    = 10;
        end
        expected.push_back({(cur_pe && bad_par) || bad_stop, data});
        for (i = 0; i < n; i++)
        begin
            rx_in <= bits[i];
            repeat (cur_p) @(posedge CLK);
        end
    endtask

    task automatic send_glitch();
        logic [15:0] r;
        int          len;
        take_bits(4, r);
        // low for less than half a bit.
        len = 1 + (int'(r[3:0]) % (cur_p / 2 - 1));
        rx_in <= 1'b0;
        repeat (len) @(posedge CLK);
        rx_in <= 1'b1;
        // receiver sits out the rest of the start bit.
        repeat (2 * cur_p) @(posedge CLK);
    endtask

    task automatic run_prescale(input int p);
        logic [15:0] r;
        take_bits(1, r);
        // good frames with parity off.
        set_mode(p, 1'b0, r[0]);
        send_frame(1'b0, 1'b0);
        idle_gap();
        send_frame(1'b0, 1'b0);
        idle_gap();
        // parity on with one frame per sense.
        set_mode(p, 1'b1, r[0]);
        send_frame(1'b0, 1'b0);
        idle_gap();
        set_mode(p, 1'b1, !r[0]);
        send_frame(1'b0, 1'b0);
        idle_gap();
        // wrong parity bit.
        send_frame(1'b1, 1'b0);
        idle_gap();
        // low stop bit.
        set_mode(p, 1'b0, cur_po);
        send_frame(1'b0, 1'b1);
        idle_gap();
        // glitch followed by a good frame.
        send_glitch();
        send_frame(1'b0, 1'b0);
        idle_gap();
        // three frames with no idle between them.
        take_bits(1, r);
        set_mode(p, r[0], cur_po);
        send_frame(1'b0, 1'b0);
        send_frame(1'b0, 1'b0);
        send_frame(1'b0, 1'b0);
        idle_gap();
    endtask

    // checks at each end-of-frame pulse.
    always @(posedge CLK)
    begin
        logic [8:0] exp_entry;
        if (RST && (rx_valid || rx_err))
        begin
            if (expected.size() == 0)
            begin
                errors++;
                $display("output pulse at %0t with no frame pending", $time);
            end
            else
            begin
                exp_entry = expected.pop_front();
                checks    = checks + 2;
                // good frames pulse valid and bad frames pulse err.
                assert ({rx_valid, rx_err} == {!exp_entry[8], exp_entry[8]})
                else
                begin
                    errors++;
                    $display("error %0t: outcome valid=%0b err=%0b, expected err=%0b",
                             $time, rx_valid, rx_err, exp_entry[8]);
                end
                assert (rx_data == exp_entry[7:0])
                else
                begin
                    errors++;
                    $display("error %0t: rx_data 0x%02h, expected 0x%02h",
                             $time, rx_data, exp_entry[7:0]);
                end
            end
        end
    end

    // hang guard.
    always @(posedge CLK)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("test hung, run not finished after %0d cycles", CYCLE_LIMIT);
            $display("checks %0d, errors %0d", checks, errors);
            $display("Simulation failed");
            $finish;
        end
    end

    initial
    begin
        int i;
        CLK      = 1'b0;
        RST      <= 1'b0;
        rx_in    <= 1'b1;
        prescale <= PRESCALE_WIDTH'(16);
        par_en   <= 1'b0;
        par_odd  <= 1'b0;
        lfsr     = 16'd70;
        cur_p    = 16;
        cur_pe   = 1'b0;
        cur_po   = 1'b0;
        errors   = 0;
        checks   = 0;
        cycles   = 0;
        repeat (16) @(posedge CLK);
        RST <= 1'b1;
        repeat (4) @(posedge CLK);
        // prescale 8, 16 and 32.
        for (i = 0; i < 3; i++)
            run_prescale(8 << i);
        // drain outstanding frames.
        while (expected.size() != 0)
            @(posedge CLK);
        repeat (8) @(posedge CLK);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/uart_rx_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_rx_assertions
(
    input wire CLK,
    input wire RST,
    input wire rx_valid,
    input wire rx_err
);

    // a frame ends good or bad, never both.
    valid_err_excl: assert property (@(posedge CLK) disable iff (!RST)
        !(rx_valid && rx_err))
        else $error("rx_valid and rx_err high in the same cycle");

    // valid is a single cycle pulse.
    valid_one_cycle: assert property (@(posedge CLK) disable iff (!RST)
        rx_valid |=> !rx_valid)
        else $error("rx_valid held high for more than one cycle");

    // same for the error pulse.
    err_one_cycle: assert property (@(posedge CLK) disable iff (!RST)
        rx_err |=> !rx_err)
        else $error("rx_err held high for more than one cycle");

    // quiet outputs under reset.
    quiet_in_reset: assert property (@(posedge CLK)
        !RST |-> (!rx_valid && !rx_err))
        else $error("output pulse while reset is asserted");

endmodule

`default_nettype wire

/* rtl/uart_rx_top.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_rx_top
#(
    parameter int PRESCALE_WIDTH = 6
)
(
    input  wire                               CLK,
    input  wire                               RST,
    input  wire                               rx_in,
    input  wire  [PRESCALE_WIDTH-1:0]         prescale,
    input  wire                               par_en,
    input  wire                               par_odd,
    output logic [uart_rx_pkg::DATA_BITS-1:0] rx_data,
    output logic                              rx_valid,
    output logic                              rx_err
);

    // fsm enables.
    logic                                  cnt_en;
    logic                                  samp_en;
    logic                                  deser_en;
    logic                                  strt_chk_en;
    logic                                  par_chk_en;
    logic                                  stp_chk_en;
    // time base.
    logic [PRESCALE_WIDTH-1:0]             edge_cnt;
    logic [uart_rx_pkg::BIT_CNT_WIDTH-1:0] bit_cnt;
    logic                                  bit_done;
    // sampler vote.
    logic                                  samp_bit;
    logic                                  samp_done;
    // checker flags.
    logic                                  strt_glitch;
    logic                                  par_err;
    logic                                  stp_err;

    uart_rx_fsm i_fsm (
        .CLK         (CLK),
        .RST         (RST),
        .rx_in       (rx_in),
        .par_en      (par_en),
        .bit_done    (bit_done),
        .bit_cnt     (bit_cnt),
        .strt_glitch (strt_glitch),
        .par_err     (par_err),
        .stp_err     (stp_err),
        .cnt_en      (cnt_en),
        .samp_en     (samp_en),
        .deser_en    (deser_en),
        .strt_chk_en (strt_chk_en),
        .par_chk_en  (par_chk_en),
        .stp_chk_en  (stp_chk_en),
        .rx_valid    (rx_valid),
        .rx_err      (rx_err)
    );

    uart_rx_bit_timer #(
        .PRESCALE_WIDTH (PRESCALE_WIDTH)
    ) i_bit_timer (
        .CLK      (CLK),
        .RST      (RST),
        .cnt_en   (cnt_en),
        .prescale (prescale),
        .edge_cnt (edge_cnt),
        .bit_cnt  (bit_cnt),
        .bit_done (bit_done)
    );

    uart_rx_data_sampler #(
        .PRESCALE_WIDTH (PRESCALE_WIDTH)
    ) i_data_sampler (
        .CLK       (CLK),
        .RST       (RST),
        .samp_en   (samp_en),
        .rx_in     (rx_in),
        .prescale  (prescale),
        .edge_cnt  (edge_cnt),
        .samp_bit  (samp_bit),
        .samp_done (samp_done)
    );

    uart_rx_deserializer i_deserializer (
        .CLK       (CLK),
        .RST       (RST),
        .deser_en  (deser_en),
        .samp_done (samp_done),
        .samp_bit  (samp_bit),
        .rx_data   (rx_data)
    );

    uart_rx_frame_checker i_frame_checker (
        .CLK         (CLK),
        .RST         (RST),
        .strt_chk_en (strt_chk_en),
        .par_chk_en  (par_chk_en),
        .stp_chk_en  (stp_chk_en),
        .par_odd     (par_odd),
        .samp_done   (samp_done),
        .samp_bit    (samp_bit),
        .rx_data     (rx_data),
        .strt_glitch (strt_glitch),
        .par_err     (par_err),
        .stp_err     (stp_err)
    );

endmodule

`default_nettype wire

/* rtl/uart_rx_frame_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_rx_frame_checker
(
    input  wire                               CLK,
    input  wire                               RST,
    input  wire                               strt_chk_en,
    input  wire                               par_chk_en,
    input  wire                               stp_chk_en,
    input  wire                               par_odd,
    input  wire                               samp_done,
    input  wire                               samp_bit,
    input  wire  [uart_rx_pkg::DATA_BITS-1:0] rx_data,
    output logic                              strt_glitch,
    output logic                              par_err,
    output logic                              stp_err
);

    // any check running.
    logic chk_active;
    // parity bit the sender should have put on the line.
    logic exp_par;

    assign chk_active = strt_chk_en || par_chk_en || stp_chk_en;

    // even parity by default, flipped for odd.
    assign exp_par = (^rx_data) ^ par_odd;

    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
        begin
            strt_glitch <= 1'b0;
            par_err     <= 1'b0;
            stp_err     <= 1'b0;
        end
        else if (!chk_active)
        begin
            // idle or between checks.
            strt_glitch <= 1'b0;
            par_err     <= 1'b0;
            stp_err     <= 1'b0;
        end
        else if (samp_done)
        begin
            // start bit must vote low.
            if (strt_chk_en)
                strt_glitch <= samp_bit;
            if (par_chk_en)
                par_err <= (samp_bit != exp_par);
            // stop bit must vote high.
            if (stp_chk_en)
                stp_err <= !samp_bit;
        end
    end

endmodule

`default_nettype wire

/* rtl/uart_rx_deserializer.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_rx_deserializer
(
    input  wire                               CLK,
    input  wire                               RST,
    input  wire                               deser_en,
    input  wire                               samp_done,
    input  wire                               samp_bit,
    output logic [uart_rx_pkg::DATA_BITS-1:0] rx_data
);

    // lsb arrives first, so shift right from the top.
    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
            rx_data <= '0;
        else if (deser_en && samp_done)
            rx_data <= {samp_bit, rx_data[uart_rx_pkg::DATA_BITS-1:1]};
    end

endmodule

`default_nettype wire

/* rtl/uart_rx_data_sampler.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_rx_data_sampler
#(
    parameter int PRESCALE_WIDTH = 6
)
(
    input  wire                        CLK,
    input  wire                        RST,
    input  wire                        samp_en,
    input  wire                        rx_in,
    input  wire  [PRESCALE_WIDTH-1:0]  prescale,
    input  wire  [PRESCALE_WIDTH-1:0]  edge_cnt,
    output logic                       samp_bit,
    output logic                       samp_done
);

    // sample points around the bit middle.
    logic [PRESCALE_WIDTH-1:0] mid_edge;
    logic [PRESCALE_WIDTH-1:0] early_edge;
    logic [PRESCALE_WIDTH-1:0] late_edge;
    // the three line samples, oldest in bit 0.
    logic [2:0]                samples;

    assign mid_edge   = prescale >> 1;
    assign early_edge = mid_edge - PRESCALE_WIDTH'(1);
    assign late_edge  = mid_edge + PRESCALE_WIDTH'(1);

    always_ff @(posedge CLK)
    begin
        if (samp_en && (edge_cnt == early_edge))
            samples[0] <= rx_in;
        if (samp_en && (edge_cnt == mid_edge))
            samples[1] <= rx_in;
        if (samp_en && (edge_cnt == late_edge))
            samples[2] <= rx_in;
    end

    // vote ready the cycle after the last sample.
    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
            samp_done <= 1'b0;
        else
            samp_done <= samp_en && (edge_cnt == late_edge);
    end

    // two of three wins, single cycle noise drops out.
    assign samp_bit = (samples[0] & samples[1]) |
                      (samples[0] & samples[2]) |
                      (samples[1] & samples[2]);

endmodule

`default_nettype wire

/* rtl/uart_rx_bit_timer.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_rx_bit_timer
#(
    parameter int PRESCALE_WIDTH = 6
)
(
    input  wire                                   CLK,
    input  wire                                   RST,
    input  wire                                   cnt_en,
    input  wire  [PRESCALE_WIDTH-1:0]             prescale,
    output logic [PRESCALE_WIDTH-1:0]             edge_cnt,
    output logic [uart_rx_pkg::BIT_CNT_WIDTH-1:0] bit_cnt,
    output logic                                  bit_done
);

    // last oversampling edge of a bit.
    logic [PRESCALE_WIDTH-1:0] last_edge;

    assign last_edge = prescale - PRESCALE_WIDTH'(1);

    // high only while counting.
    assign bit_done = cnt_en && (edge_cnt == last_edge);

    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
        begin
            edge_cnt <= '0;
            bit_cnt  <= '0;
        end
        else if (!cnt_en)
        begin
            // idle time base.
            edge_cnt <= '0;
            bit_cnt  <= '0;
        end
        else if (bit_done)
        begin
            // wrap and move to the next frame bit.
            edge_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
        end
        else
            edge_cnt <= edge_cnt + 1'b1;
    end

endmodule

`default_nettype wire

/* rtl/uart_rx_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_rx_fsm
(
    input  wire                                  CLK,
    input  wire                                  RST,
    input  wire                                  rx_in,
    input  wire                                  par_en,
    input  wire                                  bit_done,
    input  wire  [uart_rx_pkg::BIT_CNT_WIDTH-1:0] bit_cnt,
    input  wire                                  strt_glitch,
    input  wire                                  par_err,
    input  wire                                  stp_err,
    output logic                                 cnt_en,
    output logic                                 samp_en,
    output logic                                 deser_en,
    output logic                                 strt_chk_en,
    output logic                                 par_chk_en,
    output logic                                 stp_chk_en,
    output logic                                 rx_valid,
    output logic                                 rx_err
);

    uart_rx_pkg::rx_state_e state;
    uart_rx_pkg::rx_state_e next_state;

    // index of the stop bit for this frame.
    logic [uart_rx_pkg::BIT_CNT_WIDTH-1:0] stop_idx;

    // without parity the stop bit takes the parity slot.
    assign stop_idx = par_en ? uart_rx_pkg::STOP_BIT_IDX : uart_rx_pkg::PARITY_BIT_IDX;

    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
            state <= uart_rx_pkg::st_idle;
        else
            state <= next_state;
    end

    // frame sequencing.
    always_comb
    begin
        next_state = state;
        case (state)
            uart_rx_pkg::st_idle:
            begin
                if (!rx_in)
                    next_state = uart_rx_pkg::st_start;
            end
            uart_rx_pkg::st_start:
            begin
                // a high start sample means a glitch, drop the frame silently.
                if (bit_done && (bit_cnt == uart_rx_pkg::START_BIT_IDX))
                    next_state = strt_glitch ? uart_rx_pkg::st_idle : uart_rx_pkg::st_data;
            end
            uart_rx_pkg::st_data:
            begin
                if (bit_done && (bit_cnt == uart_rx_pkg::LAST_DATA_IDX))
                    next_state = par_en ? uart_rx_pkg::st_parity : uart_rx_pkg::st_stop;
            end
            uart_rx_pkg::st_parity:
            begin
                if (bit_done && (bit_cnt == uart_rx_pkg::PARITY_BIT_IDX))
                    next_state = uart_rx_pkg::st_stop;
            end
            uart_rx_pkg::st_stop:
            begin
                if (bit_done && (bit_cnt == stop_idx))
                    next_state = uart_rx_pkg::st_err_chk;
            end
            uart_rx_pkg::st_err_chk:
            begin
                if (par_err || stp_err)
                    next_state = uart_rx_pkg::st_idle;
                else
                    next_state = uart_rx_pkg::st_valid;
            end
            uart_rx_pkg::st_valid:
            begin
                // next start bit may already be on the line.
                next_state = rx_in ? uart_rx_pkg::st_idle : uart_rx_pkg::st_start;
            end
            default:
                next_state = uart_rx_pkg::st_idle;
        endcase
    end

    // enables decoded from the state.
    always_comb
    begin
        cnt_en      = 1'b0;
        samp_en     = 1'b0;
        deser_en    = 1'b0;
        strt_chk_en = 1'b0;
        par_chk_en  = 1'b0;
        stp_chk_en  = 1'b0;
        rx_valid    = 1'b0;
        rx_err      = 1'b0;
        case (state)
            uart_rx_pkg::st_idle:
            begin
                // low line starts the time base in this same cycle.
                cnt_en      = !rx_in;
                samp_en     = !rx_in;
                strt_chk_en = !rx_in;
            end
            uart_rx_pkg::st_start:
            begin
                cnt_en      = 1'b1;
                samp_en     = 1'b1;
                strt_chk_en = 1'b1;
            end
            uart_rx_pkg::st_data:
            begin
                cnt_en   = 1'b1;
                samp_en  = 1'b1;
                deser_en = 1'b1;
            end
            uart_rx_pkg::st_parity:
            begin
                cnt_en     = 1'b1;
                samp_en    = 1'b1;
                par_chk_en = 1'b1;
            end
            uart_rx_pkg::st_stop:
            begin
                cnt_en     = 1'b1;
                samp_en    = 1'b1;
                stp_chk_en = 1'b1;
            end
            uart_rx_pkg::st_err_chk:
                rx_err = par_err || stp_err;
            uart_rx_pkg::st_valid:
            begin
                rx_valid    = 1'b1;
                // back to back start, same as idle.
                cnt_en      = !rx_in;
                samp_en     = !rx_in;
                strt_chk_en = !rx_in;
            end
            default:
                rx_err = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/uart_rx_pkg.sv */
`default_nettype none

package uart_rx_pkg;

    // data bits per frame, also the received byte width.
    localparam int unsigned DATA_BITS = 8;

    // bit counter width, frame indexes run up to 10.
    localparam int unsigned BIT_CNT_WIDTH = 4;

    // frame bit indexes.
    localparam logic [BIT_CNT_WIDTH-1:0] START_BIT_IDX  = 4'd0;
    localparam logic [BIT_CNT_WIDTH-1:0] LAST_DATA_IDX  = 4'd8;
    localparam logic [BIT_CNT_WIDTH-1:0] PARITY_BIT_IDX = 4'd9;
    // stop bit with parity on, it moves to index 9 otherwise.
    localparam logic [BIT_CNT_WIDTH-1:0] STOP_BIT_IDX   = 4'd10;

    // receiver frame states.
    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_parity,
        st_stop,
        st_err_chk,
        st_valid
    } rx_state_e;

endpackage

`default_nettype wire
